// File: Makefile
# Verilator build and run of the SPI-mode SD command path testbench

VERILATOR ?= verilator
TOP       ?= sd_spi_tb
FILELIST  ?= sd_spi.f
BUILD_DIR ?= build
LOG       ?= $(BUILD_DIR)/sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		-Mdir $(BUILD_DIR) -o V$(TOP)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR)

// File: dv/sd_card_model.sv
// Behavioral SPI-mode SD card
//   Captures 48-bit commands from mosi, answers on miso by command index
//   Random answer delay of 1 to 8 cycles

`timescale 1ns/1ps
`default_nettype none

`include "sd_spi_defs.svh"

module sd_card_model (
  input  logic clock,
  input  logic cs_n,
  input  logic sclk,
  input  logic mosi,
  output logic miso,
  output logic busy
);

  integer seed;

  function automatic logic [6:0] crc7_of(input logic [39:0] bits);
    logic [6:0] crc;
    logic       fb;
    crc = '0;
    for (int i = 39; i >= 0; i--) begin
      fb  = crc[6] ^ bits[i];
      crc = {crc[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
    end
    return crc;
  endfunction

  function automatic logic [15:0] crc16_step(input logic [15:0] crc, input logic bit_in);
    logic fb;
    fb = crc[15] ^ bit_in;
    return {crc[14:0], 1'b0} ^ (fb ? 16'h1021 : 16'h0000);
  endfunction

  // Frame starts at the first low bit on mosi
  task automatic receive_command(output logic [47:0] cmd);
    int count;
    count = 0;
    cmd   = '0;
    while (count < 48) begin
      @(negedge clock);
      if (!cs_n && sclk && (count > 0 || !mosi)) begin
        cmd   = {cmd[46:0], mosi};
        count = count + 1;
      end
    end
  endtask

  task automatic send_bits(input logic [63:0] value, input int count);
    for (int i = count - 1; i >= 0; i--) begin
      @(posedge clock);
      miso <= value[i];
    end
  endtask

  task automatic answer_command(input logic [47:0] cmd);
    logic [5:0]  index;
    logic [31:0] argument;
    logic [15:0] crc;
    logic [7:0]  data_byte;
    int          delay;
    index    = cmd[45:40];
    argument = cmd[39:8];
    delay    = 1 + int'($unsigned($random(seed)) % 8);
    // CMD5 is never answered
    if (index == 6'd5) begin
      return;
    end
    repeat (delay) @(posedge clock);
    case (index)
      6'd8, 6'd58: send_bits({24'd0, 8'h00, argument}, 40);
      6'd13: send_bits(64'd0, 16);
      6'd17: begin
        send_bits(64'd0, 1);
        crc = '0;
        for (int i = 0; i < `SD_BLOCK_BYTES; i++) begin
          data_byte = argument[7:0] + 8'(i);
          send_bits({56'd0, data_byte}, 8);
          for (int b = 7; b >= 0; b--) begin
            crc = crc16_step(crc, data_byte[b]);
          end
        end
        // Argument bit 31 corrupts the block CRC
        if (argument[31]) begin
          crc = ~crc;
        end
        send_bits({48'd0, crc}, 16);
      end
      6'd24: begin
        send_bits(64'h05, 8);
        repeat (20) begin
          @(posedge clock);
          miso <= 1'b0;
          busy <= 1'b1;
        end
      end
      default: send_bits((cmd[7:1] == crc7_of(cmd[47:8])) ? 64'h00 : 64'h08, 8);
    endcase
    @(posedge clock);
    miso <= 1'b1;
    busy <= 1'b0;
  endtask

  initial begin
    logic [47:0] cmd;
    seed = 46;
    miso = 1'b1;
    busy = 1'b0;
    forever begin
      receive_command(cmd);
      answer_command(cmd);
    end
  end

endmodule

`default_nettype wire

// File: dv/sd_spi_tb.sv
// Top-level testbench for the SD command path
//   Table of requests with expected responses, applied in a loop
//   Paired entries run on both clients at once
//   Busy, SPI pin and ack routing monitor, watchdog

`timescale 1ns/1ps
`default_nettype none

`include "sd_spi_defs.svh"

module sd_spi_tb;

  import sd_spi_pkg::*;

  typedef struct packed {
    logic         client;
    logic         pair;
    sd_request_t  request;
    sd_response_t expected;
  } test_entry_t;

  localparam int num_entries = 11;

  logic         clock;
  logic         reset;
  logic         req_0;
  logic         req_1;
  sd_request_t  request_0;
  sd_request_t  request_1;
  logic         ack_0;
  logic         ack_1;
  sd_response_t response_0;
  sd_response_t response_1;
  logic         cs_n;
  logic         sclk;
  logic         mosi;
  logic         miso;
  logic         card_busy;
  test_entry_t  test_table [num_entries];
  logic         served [$];
  logic         last_client;
  logic         busy_seen;
  int           error_count;
  int           watchdog_cycles;

  tb_clock_gen u_clock_gen (.clock(clock), .reset(reset));

  sd_card_model u_card (
    .clock (clock),
    .cs_n  (cs_n),
    .sclk  (sclk),
    .mosi  (mosi),
    .miso  (miso),
    .busy  (card_busy)
  );

  sd_spi_top uut (
    .clock      (clock),
    .reset      (reset),
    .req_0      (req_0),
    .req_1      (req_1),
    .request_0  (request_0),
    .request_1  (request_1),
    .ack_0      (ack_0),
    .ack_1      (ack_1),
    .response_0 (response_0),
    .response_1 (response_1),
    .cs_n       (cs_n),
    .sclk       (sclk),
    .mosi       (mosi),
    .miso       (miso)
  );

  task automatic stop_on_error(input string message);
    error_count = error_count + 1;
    $display("FAIL %0t: %s", $time, message);
    $display("SOME TESTS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  // R1 with a good CRC7 and R2 read back as all zero
  function automatic sd_response_t expected_response(input sd_request_t request);
    sd_response_t resp;
    resp = '0;
    if (request.index == 6'd5) begin
      resp.timeout = 1'b1;
    end else begin
      case (request.kind)
        resp_r3_r7:      resp.data[31:0] = request.argument;
        resp_data_token: resp.data[7:0] = 8'h05;
        resp_data_block: begin
          for (int i = 0; i < `SD_BLOCK_BYTES; i++) begin
            resp.data[8*(`SD_BLOCK_BYTES-1-i) +: 8] = request.argument[7:0] + 8'(i);
          end
          resp.crc_error = request.argument[31];
        end
        default: resp.data = '0;
      endcase
    end
    return resp;
  endfunction

  function automatic int response_bits(input sd_resp_kind_t kind);
    case (kind)
      resp_r3_r7:      return 40;
      resp_data_block: return 8 * `SD_BLOCK_BYTES + 16;
      resp_r2:         return 16;
      default:         return 8;
    endcase
  endfunction

  task automatic add_entry(input int slot, input logic client, input logic pair,
                           input logic [5:0] index, input logic [31:0] argument,
                           input sd_resp_kind_t kind);
    test_table[slot].client           = client;
    test_table[slot].pair             = pair;
    test_table[slot].request.index    = index;
    test_table[slot].request.argument = argument;
    test_table[slot].request.kind     = kind;
    test_table[slot].expected         = expected_response(test_table[slot].request);
  endtask

  function automatic logic ack_of(input logic client);
    return client ? ack_1 : ack_0;
  endfunction

  task automatic run_transaction(input test_entry_t entry);
    sd_response_t got;
    logic         other_ack;
    @(posedge clock);
    if (entry.request.kind == resp_data_token) begin
      busy_seen = 1'b0;
    end
    if (entry.client) begin
      req_1     <= 1'b1;
      request_1 <= entry.request;
    end else begin
      req_0     <= 1'b1;
      request_0 <= entry.request;
    end
    do @(negedge clock); while (!ack_of(entry.client));
    served.push_back(entry.client);
    last_client = entry.client;
    got         = entry.client ? response_1 : response_0;
    other_ack   = entry.client ? ack_0 : ack_1;
    assert (got === entry.expected)
      else stop_on_error($sformatf("client %0d index %0d response mismatch",
                                   entry.client, entry.request.index));
    assert (!other_ack)
      else stop_on_error($sformatf("ack for client %0d also seen on the other client",
                                   entry.client));
    // Link released and mosi idle once the command completes
    assert (cs_n === 1'b1 && sclk === 1'b0 && mosi === 1'b1)
      else stop_on_error($sformatf("client %0d index %0d SPI pins not idle at ack",
                                   entry.client, entry.request.index));
    if (entry.request.kind == resp_data_token) begin
      assert (busy_seen && miso === 1'b1)
        else stop_on_error("data token completed before the card busy period ended");
    end
    @(posedge clock);
    if (entry.client) begin
      req_1 <= 1'b0;
    end else begin
      req_0 <= 1'b0;
    end
    do @(negedge clock); while (ack_of(entry.client));
  endtask

  // No ack may rise while the card holds miso low as busy
  always @(negedge clock) begin
    if (!reset) begin
      assert (!(ack_0 && ack_1)) else stop_on_error("ack raised to both clients");
      assert (!(card_busy && (ack_0 || ack_1)))
        else stop_on_error("ack raised while the card is busy");
      assert (sclk === !cs_n) else stop_on_error("sclk enable does not follow cs_n");
      if (card_busy) begin
        busy_seen = 1'b1;
      end
    end
  end

  initial begin
    wait (watchdog_cycles > 0);
    repeat (watchdog_cycles) @(posedge clock);
    $display("Timeout: the run did not finish within %0d cycles", watchdog_cycles);
    $display("SOME TESTS FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin
    int  i;
    int  total_bits;
    logic prior;
    req_0       = 1'b0;
    req_1       = 1'b0;
    request_0   = '0;
    request_1   = '0;
    busy_seen   = 1'b0;
    error_count = 0;
    add_entry(0, 1'b0, 1'b0, 6'd0, 32'h0000_0000, resp_r1);
    add_entry(1, 1'b1, 1'b0, 6'd55, 32'h0000_0000, resp_r1);
    add_entry(2, 1'b0, 1'b0, 6'd8, 32'h0000_01AA, resp_r3_r7);
    add_entry(3, 1'b1, 1'b0, 6'd17, 32'h0000_0010, resp_data_block);
    add_entry(4, 1'b0, 1'b0, 6'd17, 32'h8000_0003, resp_data_block);
    add_entry(5, 1'b1, 1'b0, 6'd5, 32'h0000_0000, resp_r1);
    // Client 1 served last, so client 0 goes first in this pair
    add_entry(6, 1'b0, 1'b1, 6'd24, 32'h0000_0200, resp_data_token);
    add_entry(7, 1'b1, 1'b0, 6'd13, 32'h0000_0000, resp_r2);
    add_entry(8, 1'b0, 1'b0, 6'd58, 32'h40FF_8000, resp_r3_r7);
    // Client 0 served last, so client 1 goes first here
    add_entry(9, 1'b1, 1'b1, 6'd16, 32'h0000_0200, resp_r1);
    add_entry(10, 1'b0, 1'b0, 6'd17, 32'h0000_007F, resp_data_block);
    total_bits = 0;
    for (int k = 0; k < num_entries; k++) begin
      total_bits += 48 + response_bits(test_table[k].request.kind);
    end
    // Margin covers reset, answer delays, timeouts and busy waits
    watchdog_cycles = 4 * total_bits + 2000;
    @(negedge reset);
    @(posedge clock);
    i = 0;
    while (i < num_entries) begin
      if (test_table[i].pair && (i + 1 < num_entries)) begin
        served.delete();
        prior = last_client;
        fork
          run_transaction(test_table[i]);
          run_transaction(test_table[i+1]);
        join
        assert (served.size() == 2 && served[0] == ~prior && served[1] == prior)
          else stop_on_error($sformatf("entries %0d and %0d not served in turn", i, i + 1));
        i = i + 2;
      end else begin
        run_transaction(test_table[i]);
        i = i + 1;
      end
    end
    if (error_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: dv/tb_clock_gen.sv
// Testbench clock and reset source
//   40 ns clock, reset held for 10 cycles

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  initial begin
    reset = 1'b1;
    repeat (10) @(posedge clock);
    reset <= 1'b0;
  end

endmodule

`default_nettype wire

// File: sd_spi.f
+incdir+verilog
verilog/sd_spi_pkg.sv
verilog/sd_link_arbiter.sv
verilog/sd_command_engine.sv
verilog/sd_cmd_transmitter.sv
verilog/sd_receiver.sv
verilog/sd_spi_top.sv
dv/tb_clock_gen.sv
dv/sd_card_model.sv
dv/sd_spi_tb.sv

// File: verilog/sd_cmd_transmitter.sv
// Command frame shifter for mosi
//   MSB first, one bit per clock
//   CRC7 computed over the first 40 bits and inserted before the stop bit

`timescale 1ns/1ps
`default_nettype none

`include "sd_spi_defs.svh"

module sd_cmd_transmitter (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    tx_start,
  input  logic [`SD_CMD_BITS-1:0] frame,
  output logic                    mosi,
  output logic                    tx_done
);

  localparam int unsigned count_width = $clog2(`SD_CMD_BITS + 1);

  logic [`SD_CMD_BITS-1:0] shift_reg;
  logic [count_width-1:0]  bits_left;
  logic [6:0]              crc7;
  logic                    busy;
  logic                    crc_phase;
  logic                    crc_fb;

  assign busy      = bits_left != '0;
  // Frame bits 7 down to 1 carry the CRC
  assign crc_phase = (bits_left <= count_width'(8)) && (bits_left >= count_width'(2));
  assign crc_fb    = crc7[6] ^ shift_reg[`SD_CMD_BITS-1];
  assign mosi      = !busy ? 1'b1 : (crc_phase ? crc7[6] : shift_reg[`SD_CMD_BITS-1]);
  assign tx_done   = bits_left == count_width'(1);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      bits_left <= '0;
      crc7      <= '0;
    end else if (tx_start) begin
      bits_left <= count_width'(`SD_CMD_BITS);
      crc7      <= '0;
    end else if (busy) begin
      bits_left <= bits_left - 1'b1;
      if (crc_phase) begin
        crc7 <= {crc7[5:0], 1'b0};
      end else if (bits_left > count_width'(8)) begin
        // x^7 + x^3 + 1
        crc7 <= {crc7[5:3], crc7[2] ^ crc_fb, crc7[1:0], crc_fb};
      end
    end
  end

  always_ff @(posedge clock) begin
    if (tx_start) begin
      shift_reg <= frame;
    end else if (busy) begin
      shift_reg <= {shift_reg[`SD_CMD_BITS-2:0], 1'b0};
    end
  end

endmodule

`default_nettype wire

// File: verilog/sd_command_engine.sv
// Command sequencer for the SPI link
//   Frames the command, runs transmit then receive
//   Latches the result and closes the four-phase handshake

`timescale 1ns/1ps
`default_nettype none

`include "sd_spi_defs.svh"

module sd_command_engine (
  input  logic                         clock,
  input  logic                         reset,
  input  logic                         grant_req,
  input  sd_spi_pkg::sd_request_t      grant_request,
  output logic                         grant_ack,
  output sd_spi_pkg::sd_response_t     grant_response,
  output logic                         tx_start,
  output logic [`SD_CMD_BITS-1:0]      frame,
  input  logic                         tx_done,
  output logic                         rx_start,
  output sd_spi_pkg::sd_resp_kind_t    kind,
  input  logic                         rx_done,
  input  logic                         rx_crc_error,
  input  logic                         rx_timeout,
  input  logic [8*`SD_BLOCK_BYTES-1:0] rx_data,
  output logic                         cs_n,
  output logic                         sclk_en
);

  import sd_spi_pkg::*;

  typedef enum logic [2:0] {
    st_idle,
    st_send,
    st_receive,
    st_complete,
    st_release
  } state_t;

  state_t state;

  // Receiver armed while the stop bit is on mosi
  assign rx_start = (state == st_send) && tx_done;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state     <= st_idle;
      tx_start  <= 1'b0;
      grant_ack <= 1'b0;
      cs_n      <= 1'b1;
      sclk_en   <= 1'b0;
    end else begin
      tx_start <= 1'b0;
      case (state)
        st_idle: begin
          if (grant_req) begin
            tx_start <= 1'b1;
            cs_n     <= 1'b0;
            sclk_en  <= 1'b1;
            state    <= st_send;
          end
        end
        st_send: begin
          if (tx_done) begin
            state <= st_receive;
          end
        end
        st_receive: begin
          if (rx_done) begin
            grant_ack <= 1'b1;
            cs_n      <= 1'b1;
            sclk_en   <= 1'b0;
            state     <= st_complete;
          end
        end
        // Held here while the client keeps req high
        st_complete: begin
          if (!grant_req) begin
            grant_ack <= 1'b0;
            state     <= st_release;
          end
        end
        st_release: begin
          state <= st_idle;
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if ((state == st_idle) && grant_req) begin
      // CRC7 field left zero, filled in on the way out
      frame <= {2'b01, grant_request.index, grant_request.argument, 7'd0, 1'b1};
      kind  <= grant_request.kind;
    end
    if ((state == st_receive) && rx_done) begin
      grant_response.data      <= rx_data;
      grant_response.crc_error <= rx_crc_error;
      grant_response.timeout   <= rx_timeout;
    end
  end

endmodule

`default_nettype wire

// File: verilog/sd_link_arbiter.sv
// Round-robin arbiter for two four-phase clients
//   Locks one requester until the downstream handshake closes
//   Payload type is a parameter

`timescale 1ns/1ps
`default_nettype none

module sd_link_arbiter #(
  parameter type payload_t = logic
) (
  input  logic               clock,
  input  logic               reset,
  input  logic     [1:0]     req,
  input  payload_t [1:0]     payload_in,
  output logic     [1:0]     ack,
  output logic               grant_req,
  output payload_t           grant_payload,
  input  logic               grant_ack,
  output logic               grant_id
);

  logic locked;
  logic acked;
  logic last_served;
  logic pick;

  // Prefer the client not served last
  always_comb begin
    if (req[~last_served]) begin
      pick = ~last_served;
    end else begin
      pick = last_served;
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      locked      <= 1'b0;
      acked       <= 1'b0;
      last_served <= 1'b1;
      grant_id    <= 1'b0;
    end else if (!locked) begin
      if (|req) begin
        locked   <= 1'b1;
        grant_id <= pick;
      end
    end else if (grant_ack) begin
      acked <= 1'b1;
    end else if (acked) begin
      // Handshake closed, hand priority over
      locked      <= 1'b0;
      acked       <= 1'b0;
      last_served <= grant_id;
    end
  end

  assign grant_req     = locked & req[grant_id];
  assign grant_payload = payload_in[grant_id];
  assign ack[0]        = locked & grant_ack & ~grant_id;
  assign ack[1]        = locked & grant_ack & grant_id;

endmodule

`default_nettype wire

// File: verilog/sd_receiver.sv
// Response receiver on miso
//   Waits for a start bit, counts bits by response kind
//   CRC16 check over data blocks, busy wait after a data token
//   Timeout when no start bit shows up

`timescale 1ns/1ps
`default_nettype none

`include "sd_spi_defs.svh"

module sd_receiver (
  input  logic                         clock,
  input  logic                         reset,
  input  logic                         rx_start,
  input  sd_spi_pkg::sd_resp_kind_t    kind,
  input  logic                         miso,
  output logic [8*`SD_BLOCK_BYTES-1:0] rx_data,
  output logic                         rx_done,
  output logic                         crc_error,
  output logic                         timeout
);

  import sd_spi_pkg::*;

  localparam int unsigned block_bits  = 8 * `SD_BLOCK_BYTES;
  localparam int unsigned count_width = $clog2(block_bits + 17);
  localparam int unsigned timer_width = $clog2(`SD_RESP_TIMEOUT + 1);

  typedef enum logic [1:0] {
    st_idle,
    st_wait_start,
    st_receiving,
    st_wait_busy
  } state_t;

  state_t                 state;
  logic [count_width-1:0] bits_left;
  logic [count_width-1:0] load_bits;
  logic [timer_width-1:0] timer;
  logic [15:0]            crc16;
  logic                   is_block;
  logic                   in_crc;
  logic                   crc_en;
  logic                   shift_en;
  logic                   crc_fb;

  // Bits still to come after the start bit
  always_comb begin
    case (kind)
      resp_r1, resp_data_token: load_bits = count_width'(7);
      resp_r3_r7:               load_bits = count_width'(39);
      resp_data_block:          load_bits = count_width'(block_bits + 16);
      default:                  load_bits = count_width'(15);
    endcase
  end

  assign is_block = kind == resp_data_block;
  assign in_crc   = is_block && (bits_left <= count_width'(16));
  assign crc_en   = (state == st_receiving) && (bits_left != '0);
  // Start bit goes in too, short responses keep it as their MSB
  assign shift_en = ((state == st_wait_start) && !miso) || (crc_en && !in_crc);
  assign crc_fb   = crc16[15] ^ miso;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state     <= st_idle;
      bits_left <= '0;
      timer     <= '0;
      crc16     <= '0;
      rx_done   <= 1'b0;
      crc_error <= 1'b0;
      timeout   <= 1'b0;
    end else begin
      rx_done <= 1'b0;
      if (crc_en) begin
        // x^16 + x^12 + x^5 + 1
        crc16 <= {crc16[14:12], crc16[11] ^ crc_fb, crc16[10:5],
                  crc16[4] ^ crc_fb, crc16[3:0], crc_fb};
      end
      case (state)
        st_wait_start: begin
          if (!miso) begin
            bits_left <= load_bits;
            state     <= st_receiving;
          end else if (timer == '0) begin
            timeout <= 1'b1;
            rx_done <= 1'b1;
            state   <= st_idle;
          end else begin
            timer <= timer - 1'b1;
          end
        end
        st_receiving: begin
          if (bits_left != '0) begin
            bits_left <= bits_left - 1'b1;
          end else begin
            // Zero remainder over data plus CRC
            crc_error <= is_block && (crc16 != 16'd0);
            if (kind == resp_data_token) begin
              state <= st_wait_busy;
            end else begin
              rx_done <= 1'b1;
              state   <= st_idle;
            end
          end
        end
        // Card holds miso low while busy
        st_wait_busy: begin
          if (miso) begin
            rx_done <= 1'b1;
            state   <= st_idle;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
      if (rx_start) begin
        state     <= st_wait_start;
        timer     <= timer_width'(`SD_RESP_TIMEOUT);
        crc16     <= '0;
        crc_error <= 1'b0;
        timeout   <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (rx_start) begin
      rx_data <= '0;
    end else if (shift_en) begin
      rx_data <= {rx_data[block_bits-2:0], miso};
    end
  end

endmodule

`default_nettype wire

// File: verilog/sd_spi_defs.svh
// Build-time sizes for the SPI-mode SD command path
//   SD_BLOCK_BYTES   data block length in bytes
//   SD_CMD_BITS      command frame length on mosi
//   SD_RESP_TIMEOUT  clocks to wait for a response start bit

`ifndef SD_SPI_DEFS_SVH
`define SD_SPI_DEFS_SVH

// One block read returns this many bytes plus CRC16
`define SD_BLOCK_BYTES 512

// Start bits, index, argument, CRC7 and stop bit
`define SD_CMD_BITS 48

`define SD_RESP_TIMEOUT 128

`endif

// File: verilog/sd_spi_pkg.sv
// Shared types of the SD command path
//   sd_resp_kind_t  expected response kind
//   sd_request_t    client request
//   sd_response_t   received bits and status

`default_nettype none

`include "sd_spi_defs.svh"

package sd_spi_pkg;

  typedef enum logic [2:0] {
    resp_r1         = 3'd0,
    resp_r3_r7      = 3'd1,
    resp_data_token = 3'd2,
    resp_data_block = 3'd3,
    resp_r2         = 3'd4
  } sd_resp_kind_t;

  typedef struct packed {
    logic [5:0]    index;
    logic [31:0]   argument;
    sd_resp_kind_t kind;
  } sd_request_t;

  // Data is right-aligned, upper bits zero for short responses
  typedef struct packed {
    logic [8*`SD_BLOCK_BYTES-1:0] data;
    logic                         crc_error;
    logic                         timeout;
  } sd_response_t;

endpackage

`default_nettype wire

// File: verilog/sd_spi_top.sv
// SPI-mode SD command path, two clients on one link
//   Arbiter, command engine, transmitter and receiver

`timescale 1ns/1ps
`default_nettype none

`include "sd_spi_defs.svh"

module sd_spi_top (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     req_0,
  input  logic                     req_1,
  input  sd_spi_pkg::sd_request_t  request_0,
  input  sd_spi_pkg::sd_request_t  request_1,
  output logic                     ack_0,
  output logic                     ack_1,
  output sd_spi_pkg::sd_response_t response_0,
  output sd_spi_pkg::sd_response_t response_1,
  output logic                     cs_n,
  output logic                     sclk,
  output logic                     mosi,
  input  logic                     miso
);

  import sd_spi_pkg::*;

  logic                         grant_req;
  logic                         grant_ack;
  logic                         grant_id;
  logic [1:0]                   client_ack;
  sd_request_t                  grant_request;
  sd_response_t                 grant_response;
  logic                         tx_start;
  logic                         tx_done;
  logic [`SD_CMD_BITS-1:0]      frame;
  logic                         rx_start;
  logic                         rx_done;
  logic                         rx_crc_error;
  logic                         rx_timeout;
  sd_resp_kind_t                kind;
  logic [8*`SD_BLOCK_BYTES-1:0] rx_data;

  sd_link_arbiter #(
    .payload_t (sd_request_t)
  ) u_arbiter (
    .clock         (clock),
    .reset         (reset),
    .req           ({req_1, req_0}),
    .payload_in    ({request_1, request_0}),
    .ack           (client_ack),
    .grant_req     (grant_req),
    .grant_payload (grant_request),
    .grant_ack     (grant_ack),
    .grant_id      (grant_id)
  );

  assign ack_0 = client_ack[0];
  assign ack_1 = client_ack[1];

  // Response goes back to the granted client only
  assign response_0 = grant_id ? '0 : grant_response;
  assign response_1 = grant_id ? grant_response : '0;

  sd_command_engine u_engine (
    .clock          (clock),
    .reset          (reset),
    .grant_req      (grant_req),
    .grant_request  (grant_request),
    .grant_ack      (grant_ack),
    .grant_response (grant_response),
    .tx_start       (tx_start),
    .frame          (frame),
    .tx_done        (tx_done),
    .rx_start       (rx_start),
    .kind           (kind),
    .rx_done        (rx_done),
    .rx_crc_error   (rx_crc_error),
    .rx_timeout     (rx_timeout),
    .rx_data        (rx_data),
    .cs_n           (cs_n),
    .sclk_en        (sclk)
  );

  sd_cmd_transmitter u_transmitter (
    .clock    (clock),
    .reset    (reset),
    .tx_start (tx_start),
    .frame    (frame),
    .mosi     (mosi),
    .tx_done  (tx_done)
  );

  sd_receiver u_receiver (
    .clock     (clock),
    .reset     (reset),
    .rx_start  (rx_start),
    .kind      (kind),
    .miso      (miso),
    .rx_data   (rx_data),
    .rx_done   (rx_done),
    .crc_error (rx_crc_error),
    .timeout   (rx_timeout)
  );

endmodule

`default_nettype wire
